//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module refill_unit_tb \
    -Mdir obj_dir -o refill_unit_sim \
    && ./obj_dir/refill_unit_sim | tee /dev/stderr | grep -q "STATUS: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- sim/refill_unit_tb.sv
`timescale 1ns/1ps

module refill_unit_tb;

    import refill_pkg::*;

    localparam int ID_WIDTH        = REFILL_ID_WIDTH;
    localparam int ADDR_WIDTH      = REFILL_ADDR_WIDTH;
    localparam int DATA_WIDTH      = REFILL_DATA_WIDTH;
    localparam int SEQ_WIDTH       = ID_WIDTH - 1;
    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 5;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int WAIT_LIMIT      = 50;
    localparam int WATCHDOG_NS     = (NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD;

    logic                       clk;
    logic                       rst_n;
    logic [NUM_PORTS-1:0]       miss_i;
    logic [ADDR_WIDTH-1:0]      miss_addr0_i;
    logic [ADDR_WIDTH-1:0]      miss_addr1_i;
    logic [NUM_PORTS-1:0]       busy_o;
    logic                       mem_req_o;
    logic [ADDR_WIDTH-1:0]      mem_addr_o;
    logic [ID_WIDTH-1:0]        mem_id_o;
    logic                       mem_resp_i;
    logic [ID_WIDTH-1:0]        mem_resp_id_i;
    logic [DATA_WIDTH-1:0]      mem_resp_data_i;
    logic [NUM_PORTS-1:0]       refill_done_o;
    logic [DATA_WIDTH-1:0]      refill_data_o;
    logic                       resp_error_o;
    logic [ERR_COUNT_WIDTH-1:0] err_count_o;

    // Reference model of the issued refills
    logic [ID_WIDTH-1:0]        issued_ids [$];
    int                         seq_count [NUM_PORTS];
    logic [ADDR_WIDTH-1:0]      pending_addr [NUM_PORTS];
    logic                       last_grant_port;
    string                      current_test;
    integer                     seed;

    refill_unit_top refill_unit_top_inst
    (
        .clk            (clk),
        .rst_n          (rst_n),
        .miss_i         (miss_i),
        .miss_addr0_i   (miss_addr0_i),
        .miss_addr1_i   (miss_addr1_i),
        .busy_o         (busy_o),
        .mem_req_o      (mem_req_o),
        .mem_addr_o     (mem_addr_o),
        .mem_id_o       (mem_id_o),
        .mem_resp_i     (mem_resp_i),
        .mem_resp_id_i  (mem_resp_id_i),
        .mem_resp_data_i(mem_resp_data_i),
        .refill_done_o  (refill_done_o),
        .refill_data_o  (refill_data_o),
        .resp_error_o   (resp_error_o),
        .err_count_o    (err_count_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial
    begin
        #(WATCHDOG_NS);
        stop_with_failure("Watchdog expired before all tests finished");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stop_with_failure(input string reason);
        $display("%s (test %s)", reason, current_test);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic compare(input string what, input int expected, input int actual);
        if (expected != actual)
        begin
            $display("CHECK FAILED %s: %s expected %0h actual %0h",
                     current_test, what, expected, actual);
            stop_with_failure("Value mismatch");
        end
    endtask

    // Port number on top, sequence count below
    function automatic logic [ID_WIDTH-1:0] make_id(input logic port, input int seq);
        return {port, SEQ_WIDTH'(seq)};
    endfunction

    task automatic issue_miss(input logic port, input logic [ADDR_WIDTH-1:0] addr);
        compare("idle before miss", 0, int'(busy_o[port]));
        pending_addr[port] = addr;
        if (port)
            miss_addr1_i = addr;
        else
            miss_addr0_i = addr;
        miss_i[port] = 1'b1;
        @(negedge clk);
        miss_i = '0;
        compare("busy after miss", 1, int'(busy_o[port]));
    endtask

    task automatic miss_both(input logic [ADDR_WIDTH-1:0] addr0,
                             input logic [ADDR_WIDTH-1:0] addr1);
        pending_addr[0] = addr0;
        pending_addr[1] = addr1;
        miss_addr0_i    = addr0;
        miss_addr1_i    = addr1;
        miss_i          = 2'b11;
        @(negedge clk);
        miss_i = '0;
        compare("both busy", 3, int'(busy_o));
    endtask

    // Waits for the next memory request and checks it against the model
    task automatic wait_request(output logic port, output logic [ID_WIDTH-1:0] id,
                                output int waited);
        waited = 0;
        while (mem_req_o !== 1'b1)
        begin
            if (waited >= WAIT_LIMIT)
                stop_with_failure("No memory request appeared in time");
            else
            begin
                @(negedge clk);
                waited++;
            end
        end
        id   = mem_id_o;
        port = id[ID_WIDTH-1];
        compare("request ID", int'(make_id(port, seq_count[port])), int'(id));
        compare("request address", int'(pending_addr[port]), int'(mem_addr_o));
        issued_ids.push_back(id);
        seq_count[port] = (seq_count[port] + 1) % (1 << SEQ_WIDTH);
        last_grant_port = port;
        @(negedge clk);
    endtask

    task automatic expect_no_request(input int cycles, input logic port);
        repeat (cycles)
        begin
            compare("no request while held", 0, int'(mem_req_o));
            compare("busy while held", 1, int'(busy_o[port]));
            @(negedge clk);
        end
    endtask

    task automatic send_response(input logic [ID_WIDTH-1:0] id);
        logic [DATA_WIDTH-1:0] data;
        logic                  port;
        for (int i = 0; i < issued_ids.size(); i++)
        begin
            if (issued_ids[i] == id)
            begin
                issued_ids.delete(i);
                break;
            end
        end
        data            = $random(seed);
        port            = id[ID_WIDTH-1];
        mem_resp_i      = 1'b1;
        mem_resp_id_i   = id;
        mem_resp_data_i = data;
        @(negedge clk);
        mem_resp_i = 1'b0;
        compare("refill done", port ? 2 : 1, int'(refill_done_o));
        compare("refill data", int'(data), int'(refill_data_o));
        compare("no response error", 0, int'(resp_error_o));
    endtask

    task automatic drain_responses();
        while (issued_ids.size() > 0)
            send_response(issued_ids[0]);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic test_single_miss();
        logic                port;
        logic [ID_WIDTH-1:0] id;
        int                  waited;
        current_test = "test_single_miss";
        issue_miss(1'b0, 16'h1a40);
        wait_request(port, id, waited);
        compare("grant latency", 1, waited);
        compare("request port", 0, int'(port));
        compare("first ID", 0, int'(id));
        compare("request is one pulse", 0, int'(mem_req_o));
        compare("busy after grant", 0, int'(busy_o[0]));
        send_response(id);
        compare("busy after refill", 0, int'(busy_o));
    endtask

    task automatic test_both_ports();
        logic                first_port;
        logic                second_port;
        logic                expected_first;
        logic [ID_WIDTH-1:0] id;
        int                  waited;
        current_test   = "test_both_ports";
        expected_first = !last_grant_port;   // The port not granted last is preferred
        miss_both(16'h2200, 16'h3310);
        wait_request(first_port, id, waited);
        wait_request(second_port, id, waited);
        compare("first grant follows pointer", int'(expected_first), int'(first_port));
        compare("grants alternate", int'(!first_port), int'(second_port));
        drain_responses();
    endtask

    task automatic test_id_hold();
        logic                port;
        logic [ID_WIDTH-1:0] id;
        int                  waited;
        current_test = "test_id_hold";
        issue_miss(1'b0, 16'h4000);
        wait_request(port, id, waited);
        issue_miss(1'b0, 16'h4040);
        wait_request(port, id, waited);
        issue_miss(1'b0, 16'h4080);   // Its ID is still outstanding
        expect_no_request(10, 1'b0);
        send_response(make_id(1'b0, 0));
        wait_request(port, id, waited);
        compare("reissued port", 0, int'(port));
        compare("reissued ID", 0, int'(id));
        drain_responses();
    endtask

    task automatic test_tracker_full();
        logic                port;
        logic [ID_WIDTH-1:0] id;
        int                  waited;
        current_test = "test_tracker_full";
        issue_miss(1'b0, 16'h5000);
        wait_request(port, id, waited);
        issue_miss(1'b0, 16'h5040);
        wait_request(port, id, waited);
        issue_miss(1'b1, 16'h6000);
        wait_request(port, id, waited);
        issue_miss(1'b1, 16'h6040);
        wait_request(port, id, waited);
        issue_miss(1'b0, 16'h5080);
        expect_no_request(12, 1'b0);
        send_response(issued_ids[0]);   // Oldest entry is the ID port 0 needs next
        wait_request(port, id, waited);
        compare("port after free", 0, int'(port));
        drain_responses();
    endtask

    task automatic test_unknown_resp();
        int prev_count;
        current_test    = "test_unknown_resp";
        prev_count      = int'(err_count_o);
        mem_resp_i      = 1'b1;
        mem_resp_id_i   = make_id(1'b1, 1);
        mem_resp_data_i = $random(seed);
        @(negedge clk);
        mem_resp_i = 1'b0;
        compare("response error", 1, int'(resp_error_o));
        compare("no refill done", 0, int'(refill_done_o));
        compare("error count", prev_count + 1, int'(err_count_o));
        @(negedge clk);
        compare("error is one pulse", 0, int'(resp_error_o));
    endtask

    task automatic test_out_of_order();
        logic                port;
        logic [ID_WIDTH-1:0] id;
        int                  waited;
        current_test = "test_out_of_order";
        miss_both(16'h7000, 16'h8000);
        wait_request(port, id, waited);
        wait_request(port, id, waited);
        miss_both(16'h7040, 16'h8040);
        wait_request(port, id, waited);
        wait_request(port, id, waited);
        while (issued_ids.size() > 0)
            send_response(issued_ids[issued_ids.size() - 1]);
    endtask

    initial
    begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        miss_i          = '0;
        miss_addr0_i    = '0;
        miss_addr1_i    = '0;
        mem_resp_i      = 1'b0;
        mem_resp_id_i   = '0;
        mem_resp_data_i = '0;
        seed            = 46258;
        seq_count[0]    = 0;
        seq_count[1]    = 0;
        last_grant_port = 1'b1;   // After reset port 0 is preferred
        current_test    = "reset";

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        compare("mem_req after reset", 0, int'(mem_req_o));
        compare("busy after reset", 0, int'(busy_o));
        compare("refill_done after reset", 0, int'(refill_done_o));
        compare("resp_error after reset", 0, int'(resp_error_o));
        compare("err_count after reset", 0, int'(err_count_o));

        test_single_miss();
        test_both_ports();
        test_id_hold();
        test_tracker_full();
        test_unknown_resp();
        test_out_of_order();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- source/miss_issuer.sv
`timescale 1ns/1ps

module miss_issuer
#(
    parameter int PORT_INDEX = 0,
    parameter int ID_WIDTH   = refill_pkg::REFILL_ID_WIDTH,
    parameter int ADDR_WIDTH = refill_pkg::REFILL_ADDR_WIDTH
)
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  miss_i,
    input  logic [ADDR_WIDTH-1:0] miss_addr_i,
    output logic                  busy_o,

    input  logic                  grant_i,
    output logic                  req_o,
    output logic [ADDR_WIDTH-1:0] req_addr_o,
    output logic [ID_WIDTH-1:0]   req_id_o
);

    localparam int SEQ_WIDTH = ID_WIDTH - 1;

    logic                  pending_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [SEQ_WIDTH-1:0]  seq_q;

    // A miss is only taken when nothing is held
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pending_q <= 1'b0;
            seq_q     <= '0;
        end
        else if (grant_i)
        begin
            pending_q <= 1'b0;
            seq_q     <= seq_q + 1'b1;   // Wraps through the port's IDs
        end
        else if (miss_i && !pending_q)
        begin
            pending_q <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (miss_i && !pending_q)
            addr_q <= miss_addr_i;
    end

    assign busy_o     = pending_q;
    assign req_o      = pending_q;
    assign req_addr_o = addr_q;

    // Port number sits in the top ID bit
    assign req_id_o   = {1'(PORT_INDEX), seq_q};

endmodule

//--- source/onehot_to_bin.sv
`timescale 1ns/1ps

module onehot_to_bin
#(
    parameter int ONEHOT_WIDTH = 4
)
(
    input  logic [ONEHOT_WIDTH-1:0]                                onehot_i,
    output logic [((ONEHOT_WIDTH > 1) ? $clog2(ONEHOT_WIDTH) : 1)-1:0] bin_o
);

    localparam int BIN_WIDTH = (ONEHOT_WIDTH > 1) ? $clog2(ONEHOT_WIDTH) : 1;

    // Each set bit contributes its own index, so one hot bit gives its position
    always_comb
    begin
        bin_o = '0;
        for (int i = 0; i < ONEHOT_WIDTH; i++)
        begin
            if (onehot_i[i])
                bin_o = bin_o | BIN_WIDTH'(i);
        end
    end

endmodule

//--- source/refill_arbiter.sv
`timescale 1ns/1ps

module refill_arbiter
#(
    parameter int ID_WIDTH   = refill_pkg::REFILL_ID_WIDTH,
    parameter int ADDR_WIDTH = refill_pkg::REFILL_ADDR_WIDTH
)
(
    input  logic                               clk,
    input  logic                               rst_n,

    input  logic [refill_pkg::NUM_PORTS-1:0]   req_i,
    input  logic [ADDR_WIDTH-1:0]              addr0_i,
    input  logic [ADDR_WIDTH-1:0]              addr1_i,
    input  logic [ID_WIDTH-1:0]                id0_i,
    input  logic [ID_WIDTH-1:0]                id1_i,
    output logic [refill_pkg::NUM_PORTS-1:0]   grant_o,

    output logic                               check_req_o,
    output logic [ID_WIDTH-1:0]                check_id_o,
    input  logic                               check_hit_i,
    input  logic                               full_i,
    output logic                               push_o,
    output logic [ID_WIDTH-1:0]                push_id_o,

    output logic                               mem_req_o,
    output logic [ADDR_WIDTH-1:0]              mem_addr_o,
    output logic [ID_WIDTH-1:0]                mem_id_o
);

    import refill_pkg::*;

    logic rr_ptr_q;   // Preferred port
    logic cand;
    logic grant;

    // A blocked candidate stalls both ports, there is no skipping
    assign cand        = req_i[rr_ptr_q] ? rr_ptr_q : !rr_ptr_q;
    assign check_req_o = |req_i;
    assign check_id_o  = cand ? id1_i : id0_i;
    assign grant       = check_req_o && !full_i && !check_hit_i;

    assign grant_o   = {{(NUM_PORTS-1){1'b0}}, grant} << cand;
    assign push_o    = grant;
    assign push_id_o = check_id_o;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rr_ptr_q  <= 1'b0;
            mem_req_o <= 1'b0;
        end
        else
        begin
            mem_req_o <= grant;
            if (grant)
                rr_ptr_q <= !cand;   // The port not granted goes first next time
        end
    end

    always_ff @(posedge clk)
    begin
        if (grant)
        begin
            mem_addr_o <= cand ? addr1_i : addr0_i;
            mem_id_o   <= check_id_o;
        end
    end

endmodule

//--- source/refill_pkg.sv
package refill_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Default sizes for the refill tracking unit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One port bit on top, one sequence bit below
    parameter int REFILL_ID_WIDTH   = 2;
    parameter int REFILL_ADDR_WIDTH = 16;
    parameter int REFILL_DATA_WIDTH = 32;

    parameter int TRACKER_DEPTH     = 4;

    // The arbiter and the ID format are built for exactly two ports
    parameter int NUM_PORTS         = 2;

    parameter int ERR_COUNT_WIDTH   = 8;   // Saturating unknown-response counter

endpackage

//--- source/refill_return.sv
`timescale 1ns/1ps

module refill_return
#(
    parameter int ID_WIDTH   = refill_pkg::REFILL_ID_WIDTH,
    parameter int DATA_WIDTH = refill_pkg::REFILL_DATA_WIDTH
)
(
    input  logic                                   clk,
    input  logic                                   rst_n,

    input  logic                                   resp_i,
    input  logic [ID_WIDTH-1:0]                    resp_id_i,
    input  logic [DATA_WIDTH-1:0]                  resp_data_i,
    input  logic                                   pop_error_i,

    output logic [refill_pkg::NUM_PORTS-1:0]       refill_done_o,
    output logic [DATA_WIDTH-1:0]                  refill_data_o,
    output logic                                   resp_error_o,
    output logic [refill_pkg::ERR_COUNT_WIDTH-1:0] err_count_o
);

    import refill_pkg::*;

    logic resp_good;
    logic resp_bad;

    assign resp_good = resp_i && !pop_error_i;
    assign resp_bad  = resp_i && pop_error_i;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            refill_done_o <= '0;
            resp_error_o  <= 1'b0;
            err_count_o   <= '0;
        end
        else
        begin
            // Owning port is the top ID bit
            refill_done_o <= {{(NUM_PORTS-1){1'b0}}, resp_good} << resp_id_i[ID_WIDTH-1];
            resp_error_o  <= resp_bad;
            if (resp_bad && (err_count_o != {ERR_COUNT_WIDTH{1'b1}}))
                err_count_o <= err_count_o + 1'b1;   // Holds at all ones
        end
    end

    always_ff @(posedge clk)
    begin
        if (resp_good)
            refill_data_o <= resp_data_i;
    end

endmodule

//--- source/refill_tracker.sv
`timescale 1ns/1ps

module refill_tracker
#(
    parameter int ID_WIDTH = refill_pkg::REFILL_ID_WIDTH,
    parameter int DEPTH    = refill_pkg::TRACKER_DEPTH
)
(
    input  logic                clk,
    input  logic                rst_n,

    input  logic                push_i,
    input  logic [ID_WIDTH-1:0] push_id_i,
    output logic                full_o,

    input  logic                pop_i,
    input  logic [ID_WIDTH-1:0] pop_id_i,
    output logic                pop_error_o,

    input  logic                check_req_i,
    input  logic [ID_WIDTH-1:0] check_id_i,
    output logic                check_hit_o
);

    localparam int IDX_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DEPTH-1:0]     valid_q;
    logic [ID_WIDTH-1:0]  id_table_q [DEPTH];

    logic [DEPTH-1:0]     free_onehot;
    logic [DEPTH-1:0]     pop_match;
    logic [DEPTH-1:0]     check_match;
    logic [IDX_WIDTH-1:0] push_index;
    logic [IDX_WIDTH-1:0] pop_index;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Entry search
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Lowest free entry, as a one-hot vector
    always_comb
    begin
        free_onehot = '0;
        for (int i = DEPTH - 1; i >= 0; i--)
        begin
            if (!valid_q[i])
                free_onehot = DEPTH'(1) << i;
        end
    end

    always_comb
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            pop_match[i]   = valid_q[i] && (id_table_q[i] == pop_id_i);
            check_match[i] = valid_q[i] && (id_table_q[i] == check_id_i);
        end
    end

    onehot_to_bin #(.ONEHOT_WIDTH(DEPTH)) push_enc_inst (.onehot_i(free_onehot), .bin_o(push_index));
    onehot_to_bin #(.ONEHOT_WIDTH(DEPTH)) pop_enc_inst  (.onehot_i(pop_match),   .bin_o(pop_index));

    assign full_o      = &valid_q;
    assign pop_error_o = pop_i && !(|pop_match);   // Nothing changes on a bad pop
    assign check_hit_o = check_req_i && (|check_match);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Table update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_q <= '0;
        end
        else
        begin
            // The popped entry is valid, so it never collides with the free one
            if (pop_i && (|pop_match))
                valid_q[pop_index] <= 1'b0;
            if (push_i && !full_o)
                valid_q[push_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push_i && !full_o)
            id_table_q[push_index] <= push_id_i;
    end

endmodule

//--- source/refill_unit_top.sv
`timescale 1ns/1ps

module refill_unit_top
#(
    parameter int ID_WIDTH   = refill_pkg::REFILL_ID_WIDTH,
    parameter int ADDR_WIDTH = refill_pkg::REFILL_ADDR_WIDTH,
    parameter int DATA_WIDTH = refill_pkg::REFILL_DATA_WIDTH,
    parameter int DEPTH      = refill_pkg::TRACKER_DEPTH
)
(
    input  logic                                   clk,
    input  logic                                   rst_n,

    input  logic [refill_pkg::NUM_PORTS-1:0]       miss_i,
    input  logic [ADDR_WIDTH-1:0]                  miss_addr0_i,
    input  logic [ADDR_WIDTH-1:0]                  miss_addr1_i,
    output logic [refill_pkg::NUM_PORTS-1:0]       busy_o,

    output logic                                   mem_req_o,
    output logic [ADDR_WIDTH-1:0]                  mem_addr_o,
    output logic [ID_WIDTH-1:0]                    mem_id_o,
    input  logic                                   mem_resp_i,
    input  logic [ID_WIDTH-1:0]                    mem_resp_id_i,
    input  logic [DATA_WIDTH-1:0]                  mem_resp_data_i,

    output logic [refill_pkg::NUM_PORTS-1:0]       refill_done_o,
    output logic [DATA_WIDTH-1:0]                  refill_data_o,
    output logic                                   resp_error_o,
    output logic [refill_pkg::ERR_COUNT_WIDTH-1:0] err_count_o
);

    import refill_pkg::*;

    logic [NUM_PORTS-1:0]  issue_req;
    logic [NUM_PORTS-1:0]  issue_grant;
    logic [ADDR_WIDTH-1:0] issue_addr0;
    logic [ADDR_WIDTH-1:0] issue_addr1;
    logic [ID_WIDTH-1:0]   issue_id0;
    logic [ID_WIDTH-1:0]   issue_id1;

    logic                  check_req;
    logic [ID_WIDTH-1:0]   check_id;
    logic                  check_hit;
    logic                  tracker_full;
    logic                  push;
    logic [ID_WIDTH-1:0]   push_id;
    logic                  pop_error;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    miss_issuer #(.PORT_INDEX(0), .ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) miss_issuer0_inst
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .miss_i     (miss_i[0]),
        .miss_addr_i(miss_addr0_i),
        .busy_o     (busy_o[0]),
        .grant_i    (issue_grant[0]),
        .req_o      (issue_req[0]),
        .req_addr_o (issue_addr0),
        .req_id_o   (issue_id0)
    );

    miss_issuer #(.PORT_INDEX(1), .ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) miss_issuer1_inst
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .miss_i     (miss_i[1]),
        .miss_addr_i(miss_addr1_i),
        .busy_o     (busy_o[1]),
        .grant_i    (issue_grant[1]),
        .req_o      (issue_req[1]),
        .req_addr_o (issue_addr1),
        .req_id_o   (issue_id1)
    );

    refill_arbiter #(.ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) refill_arbiter_inst
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (issue_req),
        .addr0_i    (issue_addr0),
        .addr1_i    (issue_addr1),
        .id0_i      (issue_id0),
        .id1_i      (issue_id1),
        .grant_o    (issue_grant),
        .check_req_o(check_req),
        .check_id_o (check_id),
        .check_hit_i(check_hit),
        .full_i     (tracker_full),
        .push_o     (push),
        .push_id_o  (push_id),
        .mem_req_o  (mem_req_o),
        .mem_addr_o (mem_addr_o),
        .mem_id_o   (mem_id_o)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tracking and response side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    refill_tracker #(.ID_WIDTH(ID_WIDTH), .DEPTH(DEPTH)) refill_tracker_inst
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_i     (push),
        .push_id_i  (push_id),
        .full_o     (tracker_full),
        .pop_i      (mem_resp_i),
        .pop_id_i   (mem_resp_id_i),
        .pop_error_o(pop_error),
        .check_req_i(check_req),
        .check_id_i (check_id),
        .check_hit_o(check_hit)
    );

    refill_return #(.ID_WIDTH(ID_WIDTH), .DATA_WIDTH(DATA_WIDTH)) refill_return_inst
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .resp_i       (mem_resp_i),
        .resp_id_i    (mem_resp_id_i),
        .resp_data_i  (mem_resp_data_i),
        .pop_error_i  (pop_error),
        .refill_done_o(refill_done_o),
        .refill_data_o(refill_data_o),
        .resp_error_o (resp_error_o),
        .err_count_o  (err_count_o)
    );

endmodule

//--- verilog.f
source/refill_pkg.sv
source/onehot_to_bin.sv
source/refill_tracker.sv
source/miss_issuer.sv
source/refill_arbiter.sv
source/refill_return.sv
source/refill_unit_top.sv
sim/refill_unit_tb.sv
